/* dfd_pkg.sv */
// Shared widths, register map, packet type codes and trace packet layouts
`default_nettype none

package dfd_pkg;

  // ****************************************
  // Bus and data widths
  // ****************************************
  localparam int unsigned ApbAddrWidth   = 12;
  localparam int unsigned ApbDataWidth   = 32;
  localparam int unsigned HwWordWidth    = 16;
  localparam int unsigned NumHwWords     = 16;
  localparam int unsigned DebugBusWidth  = 32;
  localparam int unsigned TimestampWidth = 32;
  localparam int unsigned DeltaWidth     = 14;
  localparam int unsigned PacketWidth    = 64;

  // ****************************************
  // Register map
  // ****************************************
  localparam logic [ApbAddrWidth-1:0] CtrlAddr       = 12'h000;
  localparam logic [ApbAddrWidth-1:0] MuxSelAddr     = 12'h004;
  localparam logic [ApbAddrWidth-1:0] SyncPeriodAddr = 12'h008;
  localparam logic [ApbAddrWidth-1:0] StatusAddr     = 12'h00C;
  localparam logic [ApbAddrWidth-1:0] ClearAddr      = 12'h010;
  // Entry i at BufferBase + 8i, low word first
  localparam logic [ApbAddrWidth-1:0] BufferBase     = 12'h100;

  // ****************************************
  // Trace packets
  // ****************************************
  typedef enum logic [1:0] {
    PktData = 2'b01,
    PktSync = 2'b10
  } pktType_e;

  // Delta saturates at all ones
  typedef struct packed {
    pktType_e                 pktType;
    logic [DeltaWidth-1:0]    delta;
    logic [15:0]              reserved;
    logic [DebugBusWidth-1:0] debugData;
  } dataPkt_s;

  typedef struct packed {
    pktType_e                  pktType;
    logic [29:0]               reserved;
    logic [TimestampWidth-1:0] timestamp;
  } syncPkt_s;

  // Type field sits in bits 63:62 of both views
  typedef union packed {
    dataPkt_s data;
    syncPkt_s sync;
  } tracePacket_u;

endpackage

`default_nettype wire

/* dfd_cfg_if.sv */
// Trace configuration interface with register, mux and capture modports
`timescale 1ns/1ps
`default_nettype none

interface dfd_cfg_if;
  logic       traceEnable;
  logic       changeOnly;
  logic [3:0] muxSelLo;
  logic [3:0] muxSelHi;
  logic [7:0] syncPeriod;

  modport regs (output traceEnable, changeOnly, muxSelLo, muxSelHi, syncPeriod);

  modport mux (input muxSelLo, muxSelHi);

  modport capture (input traceEnable, changeOnly, syncPeriod);

endinterface

`default_nettype wire

/* dfd_apb_regs.sv */
// APB slave with control registers, status word and trace buffer read window
`timescale 1ns/1ps
`default_nettype none

module dfd_apb_regs
  import dfd_pkg::*;
#(
  parameter int unsigned TraceDepth = 16,
  localparam int unsigned IdxWidth = $clog2(TraceDepth)
) (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic [ApbAddrWidth-1:0] i_paddr,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  logic [ApbDataWidth-1:0] i_pwdata,
  output logic                    o_pready,
  output logic [ApbDataWidth-1:0] o_prdata,
  output logic                    o_pslverr,
  input  logic [IdxWidth-1:0]     i_wrPtr,
  input  logic                    i_wrapped,
  input  logic [PacketWidth-1:0]  i_bufEntry,
  output logic                    o_clearStrobe,
  output logic [IdxWidth-1:0]     o_bufIndex,
  dfd_cfg_if.regs                 cfg
);

  localparam logic [ApbAddrWidth-1:0] WindowEnd = ApbAddrWidth'(BufferBase + TraceDepth * 8);

  logic                    access;
  logic                    wrEn;
  logic                    errAccess;
  logic                    mapped;
  logic                    hitCtrl;
  logic                    hitMuxSel;
  logic                    hitSync;
  logic                    hitStatus;
  logic                    hitClear;
  logic                    hitBuffer;
  logic [ApbAddrWidth-1:0] winOffset;

  logic                    traceEnable;
  logic                    changeOnly;
  logic [3:0]              muxSelLo;
  logic [3:0]              muxSelHi;
  logic [7:0]              syncPeriod;

  // ****************************************
  // Address decode
  // ****************************************
  assign hitCtrl   = (i_paddr == CtrlAddr);
  assign hitMuxSel = (i_paddr == MuxSelAddr);
  assign hitSync   = (i_paddr == SyncPeriodAddr);
  assign hitStatus = (i_paddr == StatusAddr);
  assign hitClear  = (i_paddr == ClearAddr);
  assign hitBuffer = (i_paddr >= BufferBase) && (i_paddr < WindowEnd);
  assign mapped    = hitCtrl | hitMuxSel | hitSync | hitStatus | hitClear | hitBuffer;

  // Status and buffer are read-only, Clear is write-only
  assign errAccess = !mapped || (i_pwrite && (hitStatus || hitBuffer)) ||
                     (!i_pwrite && hitClear);

  // Zero wait states, every access ends in ACCESS
  assign access    = i_psel && i_penable;
  assign wrEn      = access && i_pwrite && !errAccess;
  assign o_pready  = 1'b1;
  assign o_pslverr = access && errAccess;

  // Entry index and word select within the window
  assign winOffset     = i_paddr - BufferBase;
  assign o_bufIndex    = winOffset[IdxWidth+2:3];
  assign o_clearStrobe = wrEn && hitClear && i_pwdata[0];

  // ****************************************
  // Control registers
  // ****************************************
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      traceEnable <= 1'b0;
      changeOnly  <= 1'b0;
      muxSelLo    <= '0;
      muxSelHi    <= '0;
      syncPeriod  <= '0;
    end else if (wrEn) begin
      if (hitCtrl) begin
        traceEnable <= i_pwdata[0];
        changeOnly  <= i_pwdata[1];
      end
      if (hitMuxSel) begin
        muxSelLo <= i_pwdata[3:0];
        muxSelHi <= i_pwdata[7:4];
      end
      if (hitSync) begin
        syncPeriod <= i_pwdata[7:0];
      end
    end
  end

  assign cfg.traceEnable = traceEnable;
  assign cfg.changeOnly  = changeOnly;
  assign cfg.muxSelLo    = muxSelLo;
  assign cfg.muxSelHi    = muxSelHi;
  assign cfg.syncPeriod  = syncPeriod;

  // Read data
  always_comb begin
    o_prdata = '0;
    if (hitCtrl) begin
      o_prdata = ApbDataWidth'({changeOnly, traceEnable});
    end else if (hitMuxSel) begin
      o_prdata = ApbDataWidth'({muxSelHi, muxSelLo});
    end else if (hitSync) begin
      o_prdata = ApbDataWidth'(syncPeriod);
    end else if (hitStatus) begin
      o_prdata = ApbDataWidth'({i_wrapped, 16'(i_wrPtr)});
    end else if (hitBuffer) begin
      o_prdata = winOffset[2] ? i_bufEntry[PacketWidth-1:ApbDataWidth]
                              : i_bufEntry[ApbDataWidth-1:0];
    end
  end

endmodule

`default_nettype wire

/* dfd_debug_mux.sv */
// Registered debug mux selecting two hardware words onto the debug bus
`timescale 1ns/1ps
`default_nettype none

module dfd_debug_mux
  import dfd_pkg::*;
(
  input  logic                                   i_clk,
  input  logic                                   i_reset,
  input  logic [NumHwWords-1:0][HwWordWidth-1:0] i_hwWords,
  dfd_cfg_if.mux                                 cfg,
  output logic [DebugBusWidth-1:0]               o_debugBus
);

  logic [HwWordWidth-1:0] wordLo;
  logic [HwWordWidth-1:0] wordHi;

  // ****************************************
  // Word selection
  // ****************************************
  assign wordLo = i_hwWords[cfg.muxSelLo];
  assign wordHi = i_hwWords[cfg.muxSelHi];

  // High select lands in the upper half
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_debugBus <= '0;
    end else begin
      o_debugBus <= {wordHi, wordLo};
    end
  end

endmodule

`default_nettype wire

/* dfd_dst_capture.sv */
// Trace capture engine with tracing state, timestamp, change detection and packet build
`timescale 1ns/1ps
`default_nettype none

module dfd_dst_capture
  import dfd_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic [DebugBusWidth-1:0] i_debugBus,
  input  logic                     i_timeTick,
  input  logic                     i_traceStart,
  input  logic                     i_traceStop,
  input  logic                     i_tracePulse,
  dfd_cfg_if.capture               cfg,
  output logic                     o_pktStrobe,
  output tracePacket_u             o_packet
);

  logic                      tracing;
  logic                      pending;
  logic [TimestampWidth-1:0] timestamp;
  logic [DeltaWidth-1:0]     deltaCnt;
  logic [7:0]                dataCount;
  logic [DebugBusWidth-1:0]  lastData;

  logic                      startNow;
  logic                      stopNow;
  logic                      pulseNow;
  logic                      keepTracing;
  logic                      syncDue;
  logic                      dataWanted;
  logic                      emitSync;
  logic                      emitData;
  tracePacket_u              nextPkt;

  // ****************************************
  // Slot decisions
  // ****************************************
  always_comb begin
    // Stop beats start
    stopNow     = i_traceStop || !cfg.traceEnable;
    startNow    = i_traceStart && cfg.traceEnable && !i_traceStop && !tracing;
    pulseNow    = i_tracePulse && !tracing && !startNow;
    keepTracing = tracing && !stopNow;
    syncDue     = (cfg.syncPeriod != '0) && (dataCount >= cfg.syncPeriod);
    dataWanted  = !cfg.changeOnly || pending || (i_debugBus != lastData);
    emitSync    = startNow || (keepTracing && syncDue);
    emitData    = (keepTracing && !syncDue && dataWanted) || pulseNow;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      tracing   <= 1'b0;
      pending   <= 1'b0;
      dataCount <= '0;
      lastData  <= '0;
    end else begin
      tracing <= startNow || keepTracing;
      // First data after start goes out even if the bus is unchanged
      if (startNow) begin
        pending <= 1'b1;
      end else if (keepTracing) begin
        pending <= syncDue && dataWanted;
      end else begin
        pending <= 1'b0;
      end
      if (emitSync) begin
        dataCount <= '0;
      end else if (emitData && dataCount != '1) begin
        dataCount <= dataCount + 1'b1;
      end
      if (emitData) begin
        lastData <= i_debugBus;
      end
    end
  end

  // ****************************************
  // Timestamp and delta
  // ****************************************
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      timestamp <= '0;
      deltaCnt  <= '0;
    end else begin
      if (i_timeTick) begin
        timestamp <= timestamp + 1'b1;
      end
      if (emitSync || emitData) begin
        deltaCnt <= DeltaWidth'(i_timeTick);
      end else if (i_timeTick && deltaCnt != '1) begin
        deltaCnt <= deltaCnt + 1'b1;
      end
    end
  end

  // Packet build
  always_comb begin
    nextPkt = '0;
    if (emitSync) begin
      nextPkt.sync.pktType   = PktSync;
      nextPkt.sync.timestamp = timestamp;
    end else begin
      nextPkt.data.pktType   = PktData;
      nextPkt.data.delta     = deltaCnt;
      nextPkt.data.debugData = i_debugBus;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pktStrobe <= 1'b0;
    end else begin
      o_pktStrobe <= emitSync || emitData;
    end
  end

  always_ff @(posedge i_clk) begin
    if (emitSync || emitData) begin
      o_packet <= nextPkt;
    end
  end

endmodule

`default_nettype wire

/* dfd_trace_sink.sv */
// Circular trace memory with write pointer, wrap flag and asynchronous read port
`timescale 1ns/1ps
`default_nettype none

module dfd_trace_sink
  import dfd_pkg::*;
#(
  parameter int unsigned TraceDepth = 16,
  localparam int unsigned IdxWidth = $clog2(TraceDepth)
) (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_pktStrobe,
  input  tracePacket_u           i_packet,
  input  logic                   i_clearStrobe,
  input  logic [IdxWidth-1:0]    i_bufIndex,
  output logic [PacketWidth-1:0] o_bufEntry,
  output logic [IdxWidth-1:0]    o_wrPtr,
  output logic                   o_wrapped
);

  logic [PacketWidth-1:0] traceMem [TraceDepth];
  logic [IdxWidth-1:0]    wrPtr;
  logic                   wrapped;

  // ****************************************
  // Write side
  // ****************************************
  // Every strobe is accepted, no back-pressure
  always_ff @(posedge i_clk) begin
    if (i_pktStrobe) begin
      traceMem[wrPtr] <= i_packet;
    end
  end

  // Pointer wraps modulo TraceDepth
  always_ff @(posedge i_clk) begin
    if (i_reset || i_clearStrobe) begin
      wrPtr   <= '0;
      wrapped <= 1'b0;
    end else if (i_pktStrobe) begin
      wrPtr <= wrPtr + 1'b1;
      if (wrPtr == IdxWidth'(TraceDepth - 1)) begin
        wrapped <= 1'b1;
      end
    end
  end

  assign o_wrPtr   = wrPtr;
  assign o_wrapped = wrapped;

  // Read side
  assign o_bufEntry = traceMem[i_bufIndex];

endmodule

`default_nettype wire

/* dfd_top_dst.sv */
// Debug signal trace top level with registers, debug mux, capture engine and sink
`timescale 1ns/1ps
`default_nettype none

module dfd_top_dst
  import dfd_pkg::*;
#(
  parameter int unsigned TraceDepth = 16
) (
  input  logic                                   i_clk,
  input  logic                                   i_reset,
  input  logic [NumHwWords-1:0][HwWordWidth-1:0] i_hwWords,
  input  logic                                   i_timeTick,
  input  logic                                   i_traceStart,
  input  logic                                   i_traceStop,
  input  logic                                   i_tracePulse,
  // APB
  input  logic [ApbAddrWidth-1:0]                i_paddr,
  input  logic                                   i_psel,
  input  logic                                   i_penable,
  input  logic                                   i_pwrite,
  input  logic [ApbDataWidth-1:0]                i_pwdata,
  output logic                                   o_pready,
  output logic [ApbDataWidth-1:0]                o_prdata,
  output logic                                   o_pslverr
);

  localparam int unsigned IdxWidth = $clog2(TraceDepth);

  logic [DebugBusWidth-1:0] debugBus;
  logic                     pktStrobe;
  tracePacket_u             packet;
  logic                     clearStrobe;
  logic [IdxWidth-1:0]      bufIndex;
  logic [PacketWidth-1:0]   bufEntry;
  logic [IdxWidth-1:0]      wrPtr;
  logic                     wrapped;

  dfd_cfg_if u_cfgIf ();

  // ****************************************
  // Register block
  // ****************************************
  dfd_apb_regs #(
    .TraceDepth(TraceDepth)
  ) u_dfd_apb_regs (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_paddr      (i_paddr),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_pwdata     (i_pwdata),
    .o_pready     (o_pready),
    .o_prdata     (o_prdata),
    .o_pslverr    (o_pslverr),
    .i_wrPtr      (wrPtr),
    .i_wrapped    (wrapped),
    .i_bufEntry   (bufEntry),
    .o_clearStrobe(clearStrobe),
    .o_bufIndex   (bufIndex),
    .cfg          (u_cfgIf.regs)
  );

  // ****************************************
  // Trace path
  // ****************************************
  dfd_debug_mux u_dfd_debug_mux (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_hwWords (i_hwWords),
    .cfg       (u_cfgIf.mux),
    .o_debugBus(debugBus)
  );

  dfd_dst_capture u_dfd_dst_capture (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_debugBus  (debugBus),
    .i_timeTick  (i_timeTick),
    .i_traceStart(i_traceStart),
    .i_traceStop (i_traceStop),
    .i_tracePulse(i_tracePulse),
    .cfg         (u_cfgIf.capture),
    .o_pktStrobe (pktStrobe),
    .o_packet    (packet)
  );

  dfd_trace_sink #(
    .TraceDepth(TraceDepth)
  ) u_dfd_trace_sink (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_pktStrobe  (pktStrobe),
    .i_packet     (packet),
    .i_clearStrobe(clearStrobe),
    .i_bufIndex   (bufIndex),
    .o_bufEntry   (bufEntry),
    .o_wrPtr      (wrPtr),
    .o_wrapped    (wrapped)
  );

endmodule

`default_nettype wire

/* dfd_top_dst_properties.sv */
// Bound concurrent assertions on APB response, packet strobes, packet types and pointer
`timescale 1ns/1ps
`default_nettype none

module dfd_top_dst_properties
  import dfd_pkg::*;
#(
  parameter int unsigned IdxWidth = 4
) (
  input logic                   i_clk,
  input logic                   i_reset,
  input logic                   i_psel,
  input logic                   i_penable,
  input logic                   i_pready,
  input logic                   i_pslverr,
  input logic                   i_tracePulse,
  input logic                   i_tracing,
  input logic                   i_pktStrobe,
  input logic [PacketWidth-1:0] i_packet,
  input logic                   i_clearStrobe,
  input logic [IdxWidth-1:0]    i_wrPtr
);

  int failCount = 0;

  // ****************************************
  // APB response
  // ****************************************
  readyHigh: assert property (@(posedge i_clk) disable iff (i_reset) i_pready)
    else begin
      failCount++;
      $error("pready dropped low");
    end

  slverrInAccess: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pslverr |-> (i_psel && i_penable))
    else begin
      failCount++;
      $error("pslverr raised outside the ACCESS phase");
    end

  // ****************************************
  // Packet path
  // ****************************************
  // Idle strobes only follow a pulse
  strobeWhileIdle: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_pktStrobe && !i_tracing) |-> $past(i_tracePulse))
    else begin
      failCount++;
      $error("packet strobed while tracing is off and no pulse came before");
    end

  packetType: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pktStrobe |-> (i_packet[63:62] == PktData || i_packet[63:62] == PktSync))
    else begin
      failCount++;
      $error("strobed packet has an unknown type code");
    end

  pointerStep: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_pktStrobe && !i_clearStrobe) |=> (i_wrPtr == IdxWidth'($past(i_wrPtr) + 1'b1)))
    else begin
      failCount++;
      $error("write pointer did not advance by one after a strobe");
    end

endmodule

bind dfd_top_dst dfd_top_dst_properties #(
  .IdxWidth(IdxWidth)
) u_dfd_top_dst_properties (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_psel       (i_psel),
  .i_penable    (i_penable),
  .i_pready     (o_pready),
  .i_pslverr    (o_pslverr),
  .i_tracePulse (i_tracePulse),
  .i_tracing    (u_dfd_dst_capture.tracing),
  .i_pktStrobe  (pktStrobe),
  .i_packet     (packet),
  .i_clearStrobe(clearStrobe),
  .i_wrPtr      (wrPtr)
);

`default_nettype wire

/* tb_dfd_top_dst.sv */
// Testbench with clock, reset, APB tasks, trace scenarios, per-test report and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_dfd_top_dst
  import dfd_pkg::*;
();

  localparam int unsigned TraceDepth = 16;
  localparam int unsigned CycleLimit = 3000;
  localparam int unsigned SelLo      = 2;
  localparam int unsigned SelHi      = 5;

  logic                                   clk;
  logic                                   reset;
  logic [NumHwWords-1:0][HwWordWidth-1:0] hwWords;
  logic                                   timeTick;
  logic                                   traceStart;
  logic                                   traceStop;
  logic                                   tracePulse;
  logic [ApbAddrWidth-1:0]                paddr;
  logic                                   psel;
  logic                                   penable;
  logic                                   pwrite;
  logic [ApbDataWidth-1:0]                pwdata;
  logic                                   pready;
  logic [ApbDataWidth-1:0]                prdata;
  logic                                   pslverr;

  integer seed = 32'hb13f;
  int     checks = 0;
  int     errors = 0;
  int     testErrStart = 0;
  int     cycles = 0;
  int     tickCount = 0;
  logic [NumHwWords-1:0][HwWordWidth-1:0] words;
  logic [DebugBusWidth-1:0]               expQ [$];

  dfd_top_dst #(
    .TraceDepth(TraceDepth)
  ) u_dfd_top_dst (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_hwWords   (hwWords),
    .i_timeTick  (timeTick),
    .i_traceStart(traceStart),
    .i_traceStop (traceStop),
    .i_tracePulse(tracePulse),
    .i_paddr     (paddr),
    .i_psel      (psel),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_pwdata    (pwdata),
    .o_pready    (pready),
    .o_prdata    (prdata),
    .o_pslverr   (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ****************************************
  // Expected packets and checks
  // ****************************************
  function automatic logic [63:0] dataPacket(input logic [31:0] debug);
    return {2'b01, 14'h0, 16'h0, debug};
  endfunction

  function automatic logic [63:0] syncPacket(input logic [31:0] ts);
    return {2'b10, 30'h0, ts};
  endfunction

  function automatic logic [31:0] selectedWords(
    input logic [NumHwWords-1:0][HwWordWidth-1:0] w
  );
    return {w[SelHi], w[SelLo]};
  endfunction

  // Immediate check failures plus bound assertion failures
  function automatic int totalErrors();
    return errors + u_dfd_top_dst.u_dfd_top_dst_properties.failCount;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expVal,
                            input logic [63:0] gotVal);
    checks++;
    assert (gotVal === expVal) else begin
      errors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
    end
  endtask

  task automatic reportTest(input string name);
    $display("test %-12s %0d errors", name, totalErrors() - testErrStart);
    testErrStart = totalErrors();
  endtask

  // ****************************************
  // APB and stimulus tasks
  // ****************************************
  task automatic apbAccess(input logic write, input logic [ApbAddrWidth-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbWrite(input logic [ApbAddrWidth-1:0] addr, input logic [31:0] data,
                          input logic expErr);
    logic [31:0] rdata;
    logic        slverr;
    apbAccess(1'b1, addr, data, rdata, slverr);
    checkValue($sformatf("pslverr on write %h", addr), 64'(expErr), 64'(slverr));
  endtask

  task automatic apbRead(input logic [ApbAddrWidth-1:0] addr, input logic [31:0] expData,
                         input logic expErr);
    logic [31:0] rdata;
    logic        slverr;
    apbAccess(1'b0, addr, 32'h0, rdata, slverr);
    checkValue($sformatf("pslverr on read %h", addr), 64'(expErr), 64'(slverr));
    if (!expErr) begin
      checkValue($sformatf("prdata at %h", addr), 64'(expData), 64'(rdata));
    end
  endtask

  task automatic checkEntry(input int idx, input logic [63:0] expVal, input logic typeOnly);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        slverr;
    apbAccess(1'b0, ApbAddrWidth'(BufferBase + 8 * idx), 32'h0, lo, slverr);
    checkValue("pslverr on entry low word", 64'h0, 64'(slverr));
    apbAccess(1'b0, ApbAddrWidth'(BufferBase + 8 * idx + 4), 32'h0, hi, slverr);
    checkValue("pslverr on entry high word", 64'h0, 64'(slverr));
    if (typeOnly) begin
      checkValue($sformatf("entry %0d type and delta", idx), 64'(expVal[63:48]),
                 64'(hi[31:16]));
    end else begin
      checkValue($sformatf("entry %0d", idx), expVal, {hi, lo});
    end
  endtask

  task automatic randomWords();
    for (int i = 0; i < NumHwWords; i++) begin
      words[i] = 16'($random(seed));
    end
  endtask

  task automatic fireControl(input logic start, input logic stop, input logic pulse);
    @(posedge clk);
    traceStart <= start;
    traceStop  <= stop;
    tracePulse <= pulse;
    @(posedge clk);
    traceStart <= 1'b0;
    traceStop  <= 1'b0;
    tracePulse <= 1'b0;
  endtask

  // Start, then stop n cycles later, which leaves n packets
  task automatic runTrace(input int n);
    @(posedge clk);
    traceStart <= 1'b1;
    @(posedge clk);
    traceStart <= 1'b0;
    repeat (n - 1) @(posedge clk);
    traceStop <= 1'b1;
    @(posedge clk);
    traceStop <= 1'b0;
  endtask

  // ****************************************
  // Tests
  // ****************************************
  task automatic testRegisters();
    apbRead(CtrlAddr, 32'h0, 1'b0);
    apbRead(MuxSelAddr, 32'h0, 1'b0);
    apbRead(SyncPeriodAddr, 32'h0, 1'b0);
    apbRead(StatusAddr, 32'h0, 1'b0);
    apbWrite(CtrlAddr, 32'h3, 1'b0);
    apbRead(CtrlAddr, 32'h3, 1'b0);
    apbWrite(MuxSelAddr, 32'hA5, 1'b0);
    apbRead(MuxSelAddr, 32'hA5, 1'b0);
    apbWrite(SyncPeriodAddr, 32'h7F, 1'b0);
    apbRead(SyncPeriodAddr, 32'h7F, 1'b0);
    apbRead(12'h020, 32'h0, 1'b1);
    apbWrite(StatusAddr, 32'h1, 1'b1);
    apbRead(ClearAddr, 32'h0, 1'b1);
    apbWrite(BufferBase, 32'h1, 1'b1);
    apbWrite(CtrlAddr, 32'h0, 1'b0);
    apbWrite(SyncPeriodAddr, 32'h0, 1'b0);
    reportTest("registers");
  endtask

  task automatic testCapture();
    expQ.delete();
    apbWrite(MuxSelAddr, 32'({4'(SelHi), 4'(SelLo)}), 1'b0);
    apbWrite(CtrlAddr, 32'h1, 1'b0);
    repeat (7) begin
      @(posedge clk);
      timeTick <= 1'b1;
      tickCount++;
    end
    @(posedge clk);
    timeTick <= 1'b0;
    // New words every cycle and start with the first set
    for (int c = 0; c < 6; c++) begin
      @(posedge clk);
      randomWords();
      hwWords    <= words;
      traceStart <= (c == 0);
      expQ.push_back(selectedWords(words));
    end
    @(posedge clk);
    traceStart <= 1'b0;
    traceStop  <= 1'b1;
    @(posedge clk);
    traceStop <= 1'b0;
    apbRead(StatusAddr, 32'd6, 1'b0);
    checkEntry(0, syncPacket(tickCount), 1'b0);
    for (int j = 1; j < 6; j++) begin
      checkEntry(j, dataPacket(expQ[j-1]), 1'b0);
    end
    reportTest("capture");
  endtask

  task automatic testChangeOnly();
    apbWrite(ClearAddr, 32'h1, 1'b0);
    apbWrite(CtrlAddr, 32'h3, 1'b0);
    fireControl(1'b1, 1'b0, 1'b0);
    repeat (8) @(posedge clk);
    apbRead(StatusAddr, 32'd2, 1'b0);
    @(posedge clk);
    words[SelLo] = ~words[SelLo];
    hwWords <= words;
    repeat (6) @(posedge clk);
    apbRead(StatusAddr, 32'd3, 1'b0);
    checkEntry(2, dataPacket(selectedWords(words)), 1'b0);
    fireControl(1'b0, 1'b1, 1'b0);
    reportTest("change-only");
  endtask

  task automatic testControls();
    apbWrite(CtrlAddr, 32'h0, 1'b0);
    apbWrite(ClearAddr, 32'h1, 1'b0);
    fireControl(1'b1, 1'b0, 1'b0);
    repeat (4) @(posedge clk);
    apbRead(StatusAddr, 32'd0, 1'b0);
    apbWrite(CtrlAddr, 32'h1, 1'b0);
    runTrace(4);
    apbRead(StatusAddr, 32'd4, 1'b0);
    repeat (6) @(posedge clk);
    apbRead(StatusAddr, 32'd4, 1'b0);
    fireControl(1'b0, 1'b0, 1'b1);
    repeat (3) @(posedge clk);
    apbRead(StatusAddr, 32'd5, 1'b0);
    checkEntry(4, dataPacket(selectedWords(words)), 1'b0);
    reportTest("controls");
  endtask

  task automatic testSyncPeriod();
    apbWrite(ClearAddr, 32'h1, 1'b0);
    apbWrite(SyncPeriodAddr, 32'd3, 1'b0);
    runTrace(10);
    apbRead(StatusAddr, 32'd10, 1'b0);
    for (int i = 0; i < 8; i++) begin
      if (i % 4 == 0) begin
        checkEntry(i, syncPacket(tickCount), 1'b0);
      end else begin
        checkEntry(i, dataPacket(32'h0), 1'b1);
      end
    end
    reportTest("sync-period");
  endtask

  task automatic testWrap();
    apbWrite(SyncPeriodAddr, 32'h0, 1'b0);
    apbWrite(ClearAddr, 32'h1, 1'b0);
    runTrace(21);
    // 21 packets leave the pointer at 5 with wrapped set
    apbRead(StatusAddr, 32'h0001_0005, 1'b0);
    apbWrite(ClearAddr, 32'h1, 1'b0);
    apbRead(StatusAddr, 32'h0, 1'b0);
    reportTest("wrap-clear");
  endtask

  initial begin
    reset      = 1'b1;
    hwWords    = '0;
    timeTick   = 1'b0;
    traceStart = 1'b0;
    traceStop  = 1'b0;
    tracePulse = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    words      = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    testRegisters();
    testCapture();
    testChangeOnly();
    testControls();
    testSyncPeriod();
    testWrap();
    $display("checks %0d, errors %0d", checks, totalErrors());
    if (totalErrors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dfd_top_dst.f */
dfd_pkg.sv
dfd_cfg_if.sv
dfd_apb_regs.sv
dfd_debug_mux.sv
dfd_dst_capture.sv
dfd_trace_sink.sv
dfd_top_dst.sv
dfd_top_dst_properties.sv
tb_dfd_top_dst.sv

/* Makefile */
# Verilator lint and simulation of the DST slice
VERILATOR  ?= verilator
TOP        := tb_dfd_top_dst
FILELIST   := dfd_top_dst.f
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP)
OBJ_DIR    := obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
